// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbCore
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  aluOp_t               op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 flagWrite,
    output logic [dataWidth-1:0] result,
    output flags_t               flags,
    output flags_t               nextFlags
);

    flags_t flagReg;
    logic   carryOut;

    always_comb begin
        result   = '0;
        carryOut = 1'b0;
        case (op)
            passB: result = b;
            andOp: result = a & b;
            orOp:  result = a | b;
            xorOp: result = a ^ b;
            addOp: {carryOut, result} = {1'b0, a} + {1'b0, b};
            subOp: {carryOut, result} = {1'b0, a} - {1'b0, b};  // borrow lands in bit 8
            adcOp: {carryOut, result} = {1'b0, a} + {1'b0, b}
                                      + {{dataWidth{1'b0}}, flagReg.carry};
            notOp: result = ~a;
            shlOp: {carryOut, result} = {a, 1'b0};
            shrOp: {result, carryOut} = {1'b0, a};
            incOp: {carryOut, result} = {1'b0, a} + {{dataWidth{1'b0}}, 1'b1};
            decOp: {carryOut, result} = {1'b0, a} - {{dataWidth{1'b0}}, 1'b1};
            default: result = b;
        endcase
    end

    assign nextFlags.carry    = carryOut;
    assign nextFlags.zero     = (result == '0);
    assign nextFlags.negative = result[dataWidth-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg <= '0;
        end
        else if (flagWrite) begin
            flagReg <= nextFlags;
        end
    end

    assign flags = flagReg;  // stored flags, used for conditions and adc

endmodule

// File: build.f
cpuPkg.sv
instrDecoder.sv
seqControl.sv
programCounter.sv
regFile.sv
alu.sv
miniCore.sv
tbClock.sv
tbCore.sv

// File: cpuPkg.sv
package cpuPkg;

    localparam int dataWidth   = 8;
    localparam int instrWidth  = 16;
    localparam int pcWidth     = 8;
    localparam int regIdxWidth = 4;
    localparam int numRegs     = 1 << regIdxWidth;

    typedef enum logic [3:0] {
        passB = 4'd0,
        andOp = 4'd1,
        orOp  = 4'd2,
        xorOp = 4'd3,
        addOp = 4'd4,
        subOp = 4'd5,
        adcOp = 4'd6,
        notOp = 4'd8,
        shlOp = 4'd9,
        shrOp = 4'd10,
        incOp = 4'd11,
        decOp = 4'd12
    } aluOp_t;

    localparam logic [4:0] jmpCode = 5'd22;  // two-word conditional jump
    localparam logic [4:0] hltCode = 5'd29;

    typedef enum logic [2:0] {
        condAlways    = 3'd0,
        condCarry     = 3'd1,
        condNoCarry   = 3'd2,
        condZero      = 3'd3,
        condNoZero    = 3'd4,
        condNeg       = 3'd5,
        condNoNeg     = 3'd6,
        condAlwaysAlt = 3'd7
    } cond_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic [regIdxWidth-1:0] dst;
        logic [dataWidth-1:0]   imm;
        logic [2:0]             op;
        logic                   isImm;  // bit 0
    } riFields_t;

    typedef struct packed {
        logic [regIdxWidth-1:0] dst;
        logic [regIdxWidth-1:0] src;
        logic [4:0]             op;
        logic [2:0]             low;    // zero for R-R / R forms
    } rrFields_t;

    // condition sits in bits 15:13 of both views
    typedef union packed {
        riFields_t riForm;
        rrFields_t rrForm;
    } instr_t;

    typedef struct packed {
        logic               valid;
        logic [pcWidth-1:0] address;
    } fetchReq_t;

    typedef struct packed {
        logic                   valid;
        logic [regIdxWidth-1:0] idx;
        logic [dataWidth-1:0]   data;
        flags_t                 flags;
    } regCommit_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic   useImm;
        logic   regWrite;
        logic   flagWrite;
        logic   isJump;
        logic   condMet;
        logic   isHalt;
    } decodeOut_t;

endpackage

// File: instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import cpuPkg::*; (
    input  instr_t     instr,
    input  flags_t     flags,
    output decodeOut_t dec
);

    cond_t      cond;
    logic [4:0] rrOp;

    assign cond = cond_t'(instr.rrForm.dst[3:1]);  // bits 15:13
    assign rrOp = instr.rrForm.op;

    always_comb begin
        dec = '0;  // no-op unless a form matches
        dec.aluOp = passB;

        case (cond)
            condCarry:   dec.condMet = flags.carry;
            condNoCarry: dec.condMet = !flags.carry;
            condZero:    dec.condMet = flags.zero;
            condNoZero:  dec.condMet = !flags.zero;
            condNeg:     dec.condMet = flags.negative;
            condNoNeg:   dec.condMet = !flags.negative;
            default:     dec.condMet = 1'b1;  // codes 0 and 7
        endcase

        if (instr.riForm.isImm && instr.riForm.op != 3'b111) begin
            // immediate form, op 0..6 map straight onto the ALU codes
            dec.aluOp     = aluOp_t'({1'b0, instr.riForm.op});
            dec.useImm    = 1'b1;
            dec.regWrite  = 1'b1;
            dec.flagWrite = 1'b1;
        end
        else if (instr.rrForm.low == 3'b000) begin
            if (rrOp >= 5'd1 && rrOp <= 5'd12) begin
                // code 7 has no ALU op, acts as a register move
                if (rrOp == 5'd7) begin
                    dec.aluOp = passB;
                end
                else begin
                    dec.aluOp = aluOp_t'(rrOp[3:0]);
                end
                dec.regWrite  = 1'b1;
                dec.flagWrite = 1'b1;
            end
            else if (rrOp == jmpCode) begin
                dec.isJump = 1'b1;
            end
            else if (rrOp == hltCode) begin
                dec.isHalt = 1'b1;
            end
        end
    end

endmodule

// File: miniCore.sv
`timescale 1ns/1ns

module miniCore import cpuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    output fetchReq_t  fetchReq,
    input  logic       fetchReady,
    input  instr_t     instrIn,
    output regCommit_t commit,
    output logic       halted
);

    decodeOut_t           dec;
    flags_t               flags;
    flags_t               nextFlags;
    logic                 fetchValid;
    logic                 useTarget;
    logic                 pcStep;
    logic                 pcSkip;
    logic                 pcLoad;
    logic                 execWrite;
    logic [pcWidth-1:0]   pc;
    logic [dataWidth-1:0] rdA;
    logic [dataWidth-1:0] rdB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] result;

    assign fetchReq.valid   = fetchValid;
    assign fetchReq.address = useTarget ? pc + pcWidth'(1) : pc;  // target follows jump word
    assign aluB             = dec.useImm ? instrIn.riForm.imm : rdB;

    assign commit.valid = execWrite;
    assign commit.idx   = instrIn.rrForm.dst;
    assign commit.data  = result;
    assign commit.flags = nextFlags;

    instrDecoder instrDecoder_i (
        .instr (instrIn),
        .flags (flags),
        .dec   (dec)
    );

    seqControl seqControl_i (
        .clk        (clk),
        .rstN       (rstN),
        .dec        (dec),
        .fetchReady (fetchReady),
        .fetchValid (fetchValid),
        .useTarget  (useTarget),
        .pcStep     (pcStep),
        .pcSkip     (pcSkip),
        .pcLoad     (pcLoad),
        .execWrite  (execWrite),
        .halted     (halted)
    );

    programCounter programCounter_i (
        .clk    (clk),
        .rstN   (rstN),
        .step   (pcStep),
        .skip   (pcSkip),
        .load   (pcLoad),
        .target (instrIn[pcWidth-1:0]),  // low byte of the target word
        .pc     (pc)
    );

    regFile regFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .rdIdxA (instrIn.rrForm.dst),
        .rdIdxB (instrIn.rrForm.src),
        .wrEn   (execWrite),
        .wrIdx  (instrIn.rrForm.dst),
        .wrData (result),
        .rdA    (rdA),
        .rdB    (rdB)
    );

    alu alu_i (
        .clk       (clk),
        .rstN      (rstN),
        .op        (dec.aluOp),
        .a         (rdA),
        .b         (aluB),
        .flagWrite (execWrite && dec.flagWrite),
        .result    (result),
        .flags     (flags),
        .nextFlags (nextFlags)
    );

    // address comes from the pc, so it must hold while the request waits
    aAddrStable: assert property (@(posedge clk) disable iff (!rstN)
        fetchReq.valid && !fetchReady |=> $stable(fetchReq.address))
        else $error("fetch address changed while waiting");

endmodule

// File: programCounter.sv
`timescale 1ns/1ns

module programCounter import cpuPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               step,
    input  logic               skip,
    input  logic               load,
    input  logic [pcWidth-1:0] target,
    output logic [pcWidth-1:0] pc
);

    // address wraps naturally at the counter width
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end
        else if (load) begin
            pc <= target;
        end
        else if (skip) begin
            pc <= pc + pcWidth'(2);  // jump word plus its target word
        end
        else if (step) begin
            pc <= pc + pcWidth'(1);
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [regIdxWidth-1:0] rdIdxA,
    input  logic [regIdxWidth-1:0] rdIdxB,
    input  logic                   wrEn,
    input  logic [regIdxWidth-1:0] wrIdx,
    input  logic [dataWidth-1:0]   wrData,
    output logic [dataWidth-1:0]   rdA,
    output logic [dataWidth-1:0]   rdB
);

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rdA = regs[rdIdxA];  // destination operand
    assign rdB = regs[rdIdxB];

endmodule

// File: seqControl.sv
`timescale 1ns/1ns

module seqControl import cpuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  decodeOut_t dec,
    input  logic       fetchReady,
    output logic       fetchValid,
    output logic       useTarget,
    output logic       pcStep,
    output logic       pcSkip,
    output logic       pcLoad,
    output logic       execWrite,
    output logic       halted
);

    typedef enum logic [2:0] {
        sFetch,
        sExec,
        sTgtFetch,
        sTgtLoad,
        sHalted
    } state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sFetch;
        end
        else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        pcStep    = 1'b0;
        pcSkip    = 1'b0;
        pcLoad    = 1'b0;
        execWrite = 1'b0;
        case (state)
            sFetch: begin
                if (fetchReady) nextState = sExec;  // word arrives next cycle
            end
            sExec: begin
                if (dec.isHalt) begin
                    nextState = sHalted;
                end
                else if (dec.isJump && dec.condMet) begin
                    nextState = sTgtFetch;  // pc stays on the jump word
                end
                else begin
                    nextState = sFetch;
                    pcSkip    = dec.isJump;  // step over the target word
                    pcStep    = !dec.isJump;
                    execWrite = dec.regWrite;
                end
            end
            sTgtFetch: begin
                if (fetchReady) nextState = sTgtLoad;
            end
            sTgtLoad: begin
                pcLoad    = 1'b1;
                nextState = sFetch;
            end
            sHalted: nextState = sHalted;  // only reset leaves
            default: nextState = sFetch;
        endcase
    end

    assign fetchValid = (state == sFetch) || (state == sTgtFetch);
    assign useTarget  = (state == sTgtFetch) || (state == sTgtLoad);  // jump target phase
    assign halted     = (state == sHalted);

    aFetchHeld: assert property (@(posedge clk) disable iff (!rstN)
        fetchValid && !fetchReady |=> fetchValid)
        else $error("fetch request dropped before acceptance");

    aHaltQuiet: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted && !fetchValid)
        else $error("activity after halt");

    aPcOneCtl: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({pcStep, pcSkip, pcLoad}))
        else $error("conflicting pc controls");

endmodule

// File: tbClock.sv
`timescale 1ns/1ns

module tbClock (
    input  logic rstReq,
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // reset for 5 cycles at start, again on each request
    always begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #10 rstN = 1'b1;
        @(posedge rstReq);
    end

endmodule

// File: tbCore.sv
`timescale 1ns/1ns

module tbCore import cpuPkg::*; ();

    logic       clk;
    logic       rstN;
    logic       rstReq;
    logic       fetchReady;
    instr_t     instrIn;
    fetchReq_t  fetchReq;
    regCommit_t commit;
    logic       halted;

    logic [instrWidth-1:0] progMem [256];
    regCommit_t            expCommits[$];
    logic [pcWidth-1:0]    expFetches[$];
    logic [pcWidth-1:0]    lastFetch;
    int                    errors;
    int                    checks;
    int                    testsRun;
    int                    testsFailed;
    int unsigned           readyPct;
    int                    stallLeft;
    logic                  stallMode;
    logic                  hung;

    tbClock tbClock_i (
        .rstReq (rstReq),
        .clk    (clk),
        .rstN   (rstN)
    );

    miniCore miniCore_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchReq   (fetchReq),
        .fetchReady (fetchReady),
        .instrIn    (instrIn),
        .commit     (commit),
        .halted     (halted)
    );

    // expected result of one ALU op with the carry in bit 8
    function automatic logic [8:0] refAlu(input logic [3:0] op, input logic [7:0] a,
                                          input logic [7:0] b, input logic cin);
        case (op)
            4'd1:    return {1'b0, a & b};
            4'd2:    return {1'b0, a | b};
            4'd3:    return {1'b0, a ^ b};
            4'd4:    return {1'b0, a} + {1'b0, b};
            4'd5:    return {a < b, a - b};  // borrow
            4'd6:    return {1'b0, a} + {1'b0, b} + {8'd0, cin};
            4'd8:    return {1'b0, ~a};
            4'd9:    return {a, 1'b0};
            4'd10:   return {a[0], 1'b0, a[7:1]};
            4'd11:   return {a == 8'hff, a + 8'd1};
            4'd12:   return {a == 8'h00, a - 8'd1};
            default: return {1'b0, b};  // pass B and the register move
        endcase
    endfunction

    function automatic logic condHolds(input logic [2:0] c, input flags_t f);
        case (c)
            3'd1:    return f.carry;
            3'd2:    return !f.carry;
            3'd3:    return f.zero;
            3'd4:    return !f.zero;
            3'd5:    return f.negative;
            3'd6:    return !f.negative;
            default: return 1'b1;
        endcase
    endfunction

    // runs progMem on a model and fills the expected queues, returns halt address
    function automatic logic [pcWidth-1:0] refRun();
        logic [dataWidth-1:0] regs [16];
        flags_t               fl;
        regCommit_t           cm;
        logic [pcWidth-1:0]   pc;
        logic [15:0]          w;
        logic [8:0]           r;
        logic [3:0]           op;
        logic [dataWidth-1:0] b;
        logic                 isAlu;
        expCommits.delete();
        expFetches.delete();
        fl = '0;
        pc = '0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int n = 0; n < 2000; n++) begin
            w = progMem[pc];
            expFetches.push_back(pc);
            isAlu = 1'b1;
            op    = '0;
            b     = '0;
            if (w[0] && w[3:1] != 3'd7) begin
                op = {1'b0, w[3:1]};
                b  = w[11:4];
            end
            else if (w[2:0] == 3'd0 && w[7:3] >= 5'd1 && w[7:3] <= 5'd12) begin
                op = w[6:3];
                b  = regs[w[11:8]];
            end
            else begin
                isAlu = 1'b0;
            end
            if (isAlu) begin
                r = refAlu(op, regs[w[15:12]], b, fl.carry);
                regs[w[15:12]] = r[7:0];
                fl.carry    = r[8];
                fl.zero     = (r[7:0] == 8'd0);
                fl.negative = r[7];
                cm.valid = 1'b1;
                cm.idx   = w[15:12];
                cm.data  = r[7:0];
                cm.flags = fl;
                expCommits.push_back(cm);
                pc = pc + 8'd1;
            end
            else if (w[2:0] == 3'd0 && w[7:3] == jmpCode) begin
                if (condHolds(w[15:13], fl)) begin
                    expFetches.push_back(pc + 8'd1);  // target word
                    pc = progMem[pc + 8'd1][7:0];
                end
                else begin
                    pc = pc + 8'd2;
                end
            end
            else if (w[2:0] == 3'd0 && w[7:3] == hltCode) begin
                return pc;
            end
            else begin
                pc = pc + 8'd1;
            end
        end
        return pc;
    endfunction

    task automatic clearMem();
        for (int a = 0; a < 256; a++) begin
            progMem[a] = {8'(a), hltCode, 3'd0};  // halt word tagged with its address
        end
    endtask

    function automatic logic [15:0] immWord();
        return {4'($urandom), 8'($urandom), 3'($urandom_range(6)), 1'b1};
    endfunction

    task automatic buildImm();
        clearMem();
        for (int a = 0; a < 40; a++) begin
            progMem[a] = immWord();
        end
    endtask

    task automatic buildReg();
        clearMem();
        for (int a = 0; a < 16; a++) begin
            progMem[a] = {4'(a), 8'($urandom), 3'd0, 1'b1};  // preload each register
        end
        for (int a = 16; a < 64; a++) begin
            progMem[a] = {4'($urandom), 4'($urandom), 5'($urandom_range(12, 1)), 3'd0};
        end
    endtask

    // blocks of flag setter, jump, target word and a word that taken jumps may skip
    task automatic buildJump();
        int base;
        clearMem();
        for (int k = 0; k < 48; k++) begin
            base = 4 * k;
            case ((k / 8) % 3)
                0:       progMem[base] = {4'($urandom), 8'h00, 3'd1, 1'b1};  // zero set
                1:       progMem[base] = {4'($urandom), 8'h80, 3'd2, 1'b1};  // negative set
                default: progMem[base] = {4'($urandom), 8'hff, 3'd5, 1'b1};  // borrow set
            endcase
            progMem[base + 1] = {3'(k % 8), 1'($urandom), 4'($urandom), jmpCode, 3'd0};
            progMem[base + 2] = {8'($urandom), 8'(base + 3 + $urandom_range(1))};
            progMem[base + 3] = immWord();
        end
    endtask

    task automatic buildMixed();
        logic [15:0] w;
        clearMem();
        for (int a = 0; a < 60; a++) begin
            w = 16'($urandom);
            if (w[2:0] == 3'd0 && w[7:3] == jmpCode) begin
                w[3] = 1'b1;  // turns a jump into a no-op
            end
            progMem[a] = w;
        end
    endtask

    // memory responder answering one cycle after acceptance
    initial begin
        logic               accepted;
        logic [pcWidth-1:0] addr;
        logic [pcWidth-1:0] want;
        forever begin
            @(negedge clk);
            accepted = rstN && fetchReq.valid && fetchReady;
            addr     = fetchReq.address;
            @(posedge clk);
            #5;
            if (accepted) begin
                instrIn   = progMem[addr];
                lastFetch = addr;
                checks++;
                if (expFetches.size() == 0) begin
                    $display("ERR %0t: fetch of %02h with no fetch expected", $time, addr);
                    errors++;
                end
                else begin
                    want = expFetches.pop_front();
                    if (addr != want) begin
                        $display("ERR %0t: fetch of %02h, expected %02h", $time, addr, want);
                        errors++;
                    end
                end
            end
            if (stallLeft > 0) begin
                stallLeft--;
                fetchReady = 1'b0;
            end
            else if (stallMode && $urandom_range(7) == 0) begin
                stallLeft  = $urandom_range(12, 3);
                fetchReady = 1'b0;
            end
            else begin
                fetchReady = ($urandom_range(99) < readyPct);
            end
        end
    end

    always @(negedge clk) begin
        regCommit_t want;
        if (rstN && commit.valid) begin
            checks++;
            if (expCommits.size() == 0) begin
                $display("ERR %0t: commit r%0d=%02h with no commit expected",
                         $time, commit.idx, commit.data);
                errors++;
            end
            else begin
                want = expCommits.pop_front();
                if (commit != want) begin
                    $display("ERR %0t: commit r%0d=%02h flags %b, expected r%0d=%02h flags %b",
                             $time, commit.idx, commit.data, commit.flags,
                             want.idx, want.data, want.flags);
                    errors++;
                end
            end
        end
    end

    task automatic restartCore();
        int n;
        rstReq = 1'b1;
        #1;
        n = 0;
        while (!rstN && n < 20) begin
            @(negedge clk);
            n++;
        end
        rstReq = 1'b0;
        if (!rstN) begin
            $display("reset did not release within 20 cycles");
            hung = 1'b1;
        end
        else begin
            checks++;
            if (commit.valid || halted || !fetchReq.valid || fetchReq.address != 8'd0) begin
                $display("ERR %0t: after reset commit %b halted %b request %b address %02h",
                         $time, commit.valid, halted, fetchReq.valid, fetchReq.address);
                errors++;
            end
        end
    endtask

    task automatic runTest(input string name, input int unsigned pct, input logic stalls);
        logic [pcWidth-1:0] haltAddr;
        int                 errStart;
        int                 busy;
        int                 n;
        if (hung) return;
        errStart  = errors;
        readyPct  = pct;
        stallMode = stalls;
        stallLeft = 0;
        haltAddr  = refRun();
        restartCore();
        n = 0;
        while (!hung && !halted && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (!hung && !halted) begin
            $display("%s: core did not halt within 5000 cycles", name);
            hung = 1'b1;
        end
        else if (!hung) begin
            checks++;
            if (expCommits.size() != 0 || expFetches.size() != 0 || lastFetch != haltAddr) begin
                $display("ERR %0t: %0d commits and %0d fetches missing, halt at %02h, expected %02h",
                         $time, expCommits.size(), expFetches.size(), lastFetch, haltAddr);
                errors++;
            end
            busy = 0;
            for (int q = 0; q < 50; q++) begin
                @(negedge clk);
                if (fetchReq.valid || !halted) busy++;
            end
            checks++;
            if (busy != 0) begin
                $display("ERR %0t: core active in %0d cycles after halt", $time, busy);
                errors++;
            end
        end
        testsRun++;
        if (errors != errStart || hung) begin
            testsFailed++;
            $display("test %s: failed", name);
        end
        else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        void'($urandom(70728));
        rstReq      = 1'b0;
        fetchReady  = 1'b0;
        instrIn     = '0;
        lastFetch   = '0;
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        testsFailed = 0;
        readyPct    = 100;
        stallLeft   = 0;
        stallMode   = 1'b0;
        hung        = 1'b0;
        buildImm();
        runTest("immediate form", 70, 1'b0);
        buildReg();
        runTest("register form", 60, 1'b0);
        buildJump();
        runTest("conditional jumps", 80, 1'b0);
        buildMixed();
        runTest("back-pressure and halt", 50, 1'b1);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
